// File: common/eth_mux_config.svh
`ifndef ETH_MUX_CONFIG_SVH
`define ETH_MUX_CONFIG_SVH

// number of frame sources feeding the mux
`define ETH_MUX_S_COUNT 4

// payload beat width in bits
`define ETH_MUX_DATA_WIDTH 8

// tuser carries the bad-frame flag
`define ETH_MUX_USER_WIDTH 1

`endif

// File: common/eth_mux_pkg.sv
`include "eth_mux_config.svh"

package eth_mux_pkg;

    localparam int SRC_IDX_WIDTH = $clog2(`ETH_MUX_S_COUNT);

    // index of one input source
    typedef logic [SRC_IDX_WIDTH-1:0] src_idx_t;

    // control state, idle or frame in progress
    typedef enum logic {
        MUX_IDLE,
        MUX_FRAME
    } mux_state_t;

    // ethernet header, dest_mac in the top bits
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

endpackage

// File: common/eth_payload_if.sv
`include "eth_mux_config.svh"

// one payload stream between two blocks of the mux
interface eth_payload_if;

    logic [`ETH_MUX_DATA_WIDTH-1:0] tdata;
    logic [`ETH_MUX_USER_WIDTH-1:0] tuser;
    logic                           tlast;
    logic                           tvalid;
    // early ready from the receiving side
    logic                           tready;

    modport src (
        output tdata,
        output tuser,
        output tlast,
        output tvalid,
        input  tready
    );

    modport snk (
        input  tdata,
        input  tuser,
        input  tlast,
        input  tvalid,
        output tready
    );

endinterface

// File: src/eth_mux_ctrl.sv
`include "eth_mux_config.svh"

module eth_mux_ctrl import eth_mux_pkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           enable,
    input  src_idx_t                       select,
    input  logic [`ETH_MUX_S_COUNT-1:0]    s_hdr_valid,
    output logic [`ETH_MUX_S_COUNT-1:0]    s_hdr_ready,
    input  eth_hdr_t                       s_hdr    [`ETH_MUX_S_COUNT],
    input  logic [`ETH_MUX_DATA_WIDTH-1:0] s_tdata  [`ETH_MUX_S_COUNT],
    input  logic [`ETH_MUX_USER_WIDTH-1:0] s_tuser  [`ETH_MUX_S_COUNT],
    input  logic                           s_tlast  [`ETH_MUX_S_COUNT],
    input  logic                           s_tvalid [`ETH_MUX_S_COUNT],
    output logic [`ETH_MUX_S_COUNT-1:0]    s_tready,
    input  logic                           hdr_busy,
    output logic                           hdr_load,
    output eth_hdr_t                       hdr_data,
    eth_payload_if.src                     sel_payload
);

    mux_state_t state;
    mux_state_t state_next;
    src_idx_t   sel_reg;
    src_idx_t   sel_next;

    logic [`ETH_MUX_S_COUNT-1:0] hdr_ready_reg;
    logic [`ETH_MUX_S_COUNT-1:0] hdr_ready_next;
    logic [`ETH_MUX_S_COUNT-1:0] tready_reg;
    logic [`ETH_MUX_S_COUNT-1:0] tready_next;

    logic cur_tvalid;
    logic cur_tready;
    logic cur_tlast;

    assign s_hdr_ready = hdr_ready_reg;
    assign s_tready    = tready_reg;

    // stream of the locked source
    assign cur_tvalid = s_tvalid[sel_reg];
    assign cur_tready = tready_reg[sel_reg];
    assign cur_tlast  = s_tlast[sel_reg];

    assign sel_payload.tdata  = s_tdata[sel_reg];
    assign sel_payload.tuser  = s_tuser[sel_reg];
    assign sel_payload.tlast  = cur_tlast;
    // a beat only counts once our registered ready was up
    assign sel_payload.tvalid = cur_tvalid && cur_tready && (state == MUX_FRAME);

    always_comb begin
        state_next     = state;
        sel_next       = sel_reg;
        hdr_ready_next = '0;
        hdr_load       = 1'b0;
        hdr_data       = s_hdr[select];

        // frame ends on the accepted tlast beat
        if (state == MUX_FRAME && cur_tvalid && cur_tready && cur_tlast) begin
            state_next = MUX_IDLE;
        end

        // start of frame, lock the select value
        if (state == MUX_IDLE && enable && !hdr_busy && s_hdr_valid[select]) begin
            state_next             = MUX_FRAME;
            sel_next               = select;
            hdr_ready_next[select] = 1'b1;
            hdr_load               = 1'b1;
        end

        tready_next           = '0;
        tready_next[sel_next] = sel_payload.tready && (state_next == MUX_FRAME);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= MUX_IDLE;
            sel_reg       <= '0;
            hdr_ready_reg <= '0;
            tready_reg    <= '0;
        end else begin
            state         <= state_next;
            sel_reg       <= sel_next;
            hdr_ready_reg <= hdr_ready_next;
            tready_reg    <= tready_next;
        end
    end

    // at most one source sees its header taken per cycle
    a_hdr_ready_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(s_hdr_ready)
    );

    // payload ready only goes to the source locked for the current frame
    a_tready_locked: assert property (
        @(posedge clk) disable iff (rst)
        (s_tready != '0) |-> (state == MUX_FRAME) && $onehot(s_tready) && s_tready[sel_reg]
    );

endmodule

// File: src/eth_hdr_out.sv
module eth_hdr_out import eth_mux_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  eth_hdr_t hdr_in,
    output logic     busy,
    output logic     m_hdr_valid,
    input  logic     m_hdr_ready,
    output eth_hdr_t m_hdr
);

    logic     valid_reg;
    eth_hdr_t hdr_reg;

    assign m_hdr_valid = valid_reg;
    assign m_hdr       = hdr_reg;
    // blocks the next start until downstream has the header
    assign busy        = valid_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_reg <= 1'b0;
        end else if (load) begin
            valid_reg <= 1'b1;
        end else if (m_hdr_ready) begin
            valid_reg <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hdr_reg <= hdr_in;
        end
    end

    // the control block must not overwrite a pending header
    a_no_load_when_full: assert property (
        @(posedge clk) disable iff (rst)
        load |-> !valid_reg
    );

endmodule

// File: src/eth_payload_skid.sv
`include "eth_mux_config.svh"

module eth_payload_skid (
    input  logic                           clk,
    input  logic                           rst,
    eth_payload_if.snk                     in,
    output logic [`ETH_MUX_DATA_WIDTH-1:0] m_tdata,
    output logic [`ETH_MUX_USER_WIDTH-1:0] m_tuser,
    output logic                           m_tlast,
    output logic                           m_tvalid,
    input  logic                           m_tready
);

    logic                           ready_reg;

    logic [`ETH_MUX_DATA_WIDTH-1:0] out_tdata;
    logic [`ETH_MUX_USER_WIDTH-1:0] out_tuser;
    logic                           out_tlast;
    logic                           out_valid;
    logic                           out_valid_next;

    logic [`ETH_MUX_DATA_WIDTH-1:0] temp_tdata;
    logic [`ETH_MUX_USER_WIDTH-1:0] temp_tuser;
    logic                           temp_tlast;
    logic                           temp_valid;
    logic                           temp_valid_next;

    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    assign m_tdata  = out_tdata;
    assign m_tuser  = out_tuser;
    assign m_tlast  = out_tlast;
    assign m_tvalid = out_valid;

    // next cycle is safe if the output drains or temp stays empty
    assign in.tready = m_tready || (!temp_valid && (!out_valid || !in.tvalid));

    always_comb begin
        out_valid_next    = out_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_reg) begin
            if (m_tready || !out_valid) begin
                out_valid_next  = in.tvalid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next  = in.tvalid;
                store_in_to_temp = 1'b1;
            end
        end else if (m_tready) begin
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg  <= 1'b0;
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            ready_reg  <= in.tready;
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_tdata <= in.tdata;
            out_tuser <= in.tuser;
            out_tlast <= in.tlast;
        end else if (store_temp_to_out) begin
            out_tdata <= temp_tdata;
            out_tuser <= temp_tuser;
            out_tlast <= temp_tlast;
        end
        if (store_in_to_temp) begin
            temp_tdata <= in.tdata;
            temp_tuser <= in.tuser;
            temp_tlast <= in.tlast;
        end
    end

    // beats fill the output register before the temp register
    a_temp_implies_out: assert property (
        @(posedge clk) disable iff (rst)
        temp_valid |-> out_valid
    );

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        (m_tvalid && !m_tready) |=> m_tvalid && $stable(m_tdata) && $stable(m_tuser)
            && $stable(m_tlast)
    );

endmodule

// File: src/eth_mux_top.sv
`include "eth_mux_config.svh"

module eth_mux_top import eth_mux_pkg::*; (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            enable,
    input  src_idx_t                                        select,
    input  logic [`ETH_MUX_S_COUNT-1:0]                     s_hdr_valid,
    output logic [`ETH_MUX_S_COUNT-1:0]                     s_hdr_ready,
    input  logic [`ETH_MUX_S_COUNT*48-1:0]                  s_dest_mac,
    input  logic [`ETH_MUX_S_COUNT*48-1:0]                  s_src_mac,
    input  logic [`ETH_MUX_S_COUNT*16-1:0]                  s_eth_type,
    input  logic [`ETH_MUX_S_COUNT*`ETH_MUX_DATA_WIDTH-1:0] s_tdata,
    input  logic [`ETH_MUX_S_COUNT*`ETH_MUX_USER_WIDTH-1:0] s_tuser,
    input  logic [`ETH_MUX_S_COUNT-1:0]                     s_tlast,
    input  logic [`ETH_MUX_S_COUNT-1:0]                     s_tvalid,
    output logic [`ETH_MUX_S_COUNT-1:0]                     s_tready,
    output logic                                            m_hdr_valid,
    input  logic                                            m_hdr_ready,
    output logic [47:0]                                     m_dest_mac,
    output logic [47:0]                                     m_src_mac,
    output logic [15:0]                                     m_eth_type,
    output logic [`ETH_MUX_DATA_WIDTH-1:0]                  m_tdata,
    output logic [`ETH_MUX_USER_WIDTH-1:0]                  m_tuser,
    output logic                                            m_tlast,
    output logic                                            m_tvalid,
    input  logic                                            m_tready
);

    eth_hdr_t                       s_hdr_arr    [`ETH_MUX_S_COUNT];
    logic [`ETH_MUX_DATA_WIDTH-1:0] s_tdata_arr  [`ETH_MUX_S_COUNT];
    logic [`ETH_MUX_USER_WIDTH-1:0] s_tuser_arr  [`ETH_MUX_S_COUNT];
    logic                           s_tlast_arr  [`ETH_MUX_S_COUNT];
    logic                           s_tvalid_arr [`ETH_MUX_S_COUNT];

    logic     hdr_busy;
    logic     hdr_load;
    eth_hdr_t hdr_data;
    eth_hdr_t m_hdr;

    eth_payload_if sel_payload ();

    // split the flat source buses per source
    for (genvar i = 0; i < `ETH_MUX_S_COUNT; i++) begin : g_unpack
        assign s_hdr_arr[i] = '{
            dest_mac: s_dest_mac[i*48 +: 48],
            src_mac:  s_src_mac[i*48 +: 48],
            eth_type: s_eth_type[i*16 +: 16]
        };
        assign s_tdata_arr[i]  = s_tdata[i*`ETH_MUX_DATA_WIDTH +: `ETH_MUX_DATA_WIDTH];
        assign s_tuser_arr[i]  = s_tuser[i*`ETH_MUX_USER_WIDTH +: `ETH_MUX_USER_WIDTH];
        assign s_tlast_arr[i]  = s_tlast[i];
        assign s_tvalid_arr[i] = s_tvalid[i];
    end

    assign m_dest_mac = m_hdr.dest_mac;
    assign m_src_mac  = m_hdr.src_mac;
    assign m_eth_type = m_hdr.eth_type;

    eth_mux_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .select      (select),
        .s_hdr_valid (s_hdr_valid),
        .s_hdr_ready (s_hdr_ready),
        .s_hdr       (s_hdr_arr),
        .s_tdata     (s_tdata_arr),
        .s_tuser     (s_tuser_arr),
        .s_tlast     (s_tlast_arr),
        .s_tvalid    (s_tvalid_arr),
        .s_tready    (s_tready),
        .hdr_busy    (hdr_busy),
        .hdr_load    (hdr_load),
        .hdr_data    (hdr_data),
        .sel_payload (sel_payload.src)
    );

    eth_hdr_out u_hdr_out (
        .clk         (clk),
        .rst         (rst),
        .load        (hdr_load),
        .hdr_in      (hdr_data),
        .busy        (hdr_busy),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr_ready (m_hdr_ready),
        .m_hdr       (m_hdr)
    );

    eth_payload_skid u_payload_skid (
        .clk      (clk),
        .rst      (rst),
        .in       (sel_payload.snk),
        .m_tdata  (m_tdata),
        .m_tuser  (m_tuser),
        .m_tlast  (m_tlast),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready)
    );

endmodule

// File: tests/eth_mux_tb.sv
`include "eth_mux_config.svh"

module eth_mux_tb;

    localparam int NS         = `ETH_MUX_S_COUNT;
    localparam int DW         = `ETH_MUX_DATA_WIDTH;
    localparam int UW         = `ETH_MUX_USER_WIDTH;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_ROWS   = 8;
    localparam int MAX_LEN    = 16;
    localparam int ROW_LIMIT  = (MAX_LEN + 20) * 3;

    // one frame per row
    // chg_sel moves select to the next row's source mid-frame
    typedef struct packed {
        logic [$clog2(NS)-1:0] src;
        logic                  en;
        logic [7:0]            len;
        logic [7:0]            base;
        logic                  tuser;
        logic [47:0]           dest_mac;
        logic [47:0]           src_mac;
        logic [15:0]           eth_type;
        logic                  bp;
        logic                  chg_sel;
    } frame_row_t;

    frame_row_t rows [NUM_ROWS] = '{
        '{2'd0, 1'b1, 8'd8, 8'h10, 1'b0, 48'h0a0000000001, 48'h0b0000000001, 16'h0800, 1'b0, 1'b0},
        '{2'd1, 1'b1, 8'd1, 8'hf0, 1'b1, 48'h0a0000000002, 48'h0b0000000002, 16'h86dd, 1'b0, 1'b0},
        '{2'd2, 1'b1, 8'd12, 8'hfa, 1'b0, 48'h0a0000000003, 48'h0b0000000003, 16'h0806, 1'b1, 1'b0},
        '{2'd3, 1'b1, 8'd10, 8'h40, 1'b1, 48'h0a0000000004, 48'h0b0000000004, 16'h8100, 1'b0, 1'b1},
        '{2'd0, 1'b1, 8'd6, 8'h60, 1'b0, 48'h0a0000000005, 48'h0b0000000005, 16'h0800, 1'b0, 1'b0},
        '{2'd1, 1'b0, 8'd5, 8'h00, 1'b1, 48'h0a0000000006, 48'h0b0000000006, 16'h88cc, 1'b0, 1'b0},
        '{2'd3, 1'b1, 8'd16, 8'h20, 1'b1, 48'h0a0000000007, 48'h0b0000000007, 16'h0800, 1'b1, 1'b1},
        '{2'd2, 1'b1, 8'd9, 8'hc0, 1'b0, 48'h0a0000000008, 48'h0b0000000008, 16'h86dd, 1'b1, 1'b0}
    };

    logic clk, rst, enable;
    logic [$clog2(NS)-1:0] select;
    logic [NS-1:0]    s_hdr_valid, s_hdr_ready, s_tlast, s_tvalid, s_tready;
    logic [NS*48-1:0] s_dest_mac, s_src_mac;
    logic [NS*16-1:0] s_eth_type;
    logic [NS*DW-1:0] s_tdata;
    logic [NS*UW-1:0] s_tuser;
    logic m_hdr_valid, m_hdr_ready, m_tlast, m_tvalid, m_tready;
    logic [47:0] m_dest_mac, m_src_mac;
    logic [15:0] m_eth_type;
    logic [DW-1:0] m_tdata;
    logic [UW-1:0] m_tuser;

    // source models with one frame per source and row
    logic [7:0]   src_base  [NS];
    logic [7:0]   src_len   [NS];
    logic [7:0]   src_ptr   [NS];
    logic         src_tuser [NS];
    logic [111:0] src_hdr   [NS];
    logic         hdr_on    [NS];
    int           hdr_pulses [NS];

    // collected output
    logic [7:0]   got_data [$];
    logic         got_last [$];
    logic         got_user [$];
    logic [111:0] got_hdr;
    int           hdr_count;
    logic         tlast_seen, src_done, sel_moved;
    int           err_count, row_errs;

    eth_mux_top u_dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_sources(input int r);
        for (int i = 0; i < NS; i++) begin
            src_ptr[i]    = '0;
            hdr_on[i]     = 1'b1;
            hdr_pulses[i] = 0;
            if (i == rows[r].src) begin
                src_base[i]  = rows[r].base;
                src_len[i]   = rows[r].len;
                src_tuser[i] = rows[r].tuser;
                src_hdr[i]   = {rows[r].dest_mac, rows[r].src_mac, rows[r].eth_type};
            end else begin
                // other sources offer a frame too with bytes far from the row's range
                src_base[i]  = rows[r].base + 8'h80 + 8'(i * 19);
                src_len[i]   = 8'(MAX_LEN);
                src_tuser[i] = 1'b1;
                src_hdr[i]   = {48'hdec000000000 + 48'(i), 48'h0bad00000000 + 48'(r), 16'h88b5};
            end
        end
        got_data.delete();
        got_last.delete();
        got_user.delete();
        hdr_count  = 0;
        tlast_seen = 1'b0;
        src_done   = 1'b0;
        sel_moved  = 1'b0;
        select     = rows[r].src;
    endtask

    task automatic drive_sources();
        for (int i = 0; i < NS; i++) begin
            s_hdr_valid[i] = hdr_on[i];
            {s_dest_mac[i*48 +: 48], s_src_mac[i*48 +: 48], s_eth_type[i*16 +: 16]} = src_hdr[i];
            s_tvalid[i]          = !src_done && (src_ptr[i] < src_len[i]);
            s_tdata[i*DW +: DW]  = src_base[i] + src_ptr[i];
            s_tlast[i]           = (src_ptr[i] == src_len[i] - 8'd1);
            s_tuser[i*UW +: UW]  = s_tlast[i] ? src_tuser[i] : 1'b0;
        end
    endtask

    // observe, drive, then book the handshakes of the next rising edge
    task automatic step_cycle(input int r);
        logic [NS-1:0] other;
        @(negedge clk);
        other = ~(NS'(1) << rows[r].src);
        if ((s_tready & other) != '0) begin
            $display("CHECK FAILED row %0d: s_tready expected %h got %h",
                     r, s_tready & ~other, s_tready);
            row_errs++;
        end
        for (int i = 0; i < NS; i++) begin
            if (s_hdr_ready[i]) begin
                hdr_pulses[i]++;
                hdr_on[i] = 1'b0;
            end
            // once the frame is over all sources go quiet before the next start check
            if (src_done) begin
                hdr_on[i] = 1'b0;
            end
        end
        if (rows[r].chg_sel && !sel_moved && src_ptr[rows[r].src] == rows[r].len / 2) begin
            select    = rows[r + 1].src;
            sel_moved = 1'b1;
        end
        m_tready    = rows[r].bp ? ($urandom % 3 != 0) : 1'b1;
        m_hdr_ready = rows[r].bp ? ($urandom % 2 == 0) : 1'b1;
        drive_sources();
        for (int i = 0; i < NS; i++) begin
            if (s_tvalid[i] && s_tready[i]) begin
                if (i == rows[r].src && s_tlast[i]) begin
                    src_done = 1'b1;
                end
                src_ptr[i]++;
            end
        end
        if (m_tvalid && m_tready) begin
            got_data.push_back(m_tdata);
            got_last.push_back(m_tlast);
            got_user.push_back(m_tuser);
            tlast_seen = tlast_seen || m_tlast;
        end
        if (m_hdr_valid && m_hdr_ready) begin
            got_hdr = {m_dest_mac, m_src_mac, m_eth_type};
            hdr_count++;
        end
    endtask

    task automatic show_mismatch(input int r, input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        $display("CHECK FAILED row %0d: %s expected %h got %h", r, name, exp, got);
        row_errs++;
    endtask

    task automatic compare_reset_value(input string name, input logic [NS-1:0] got);
        if (got != '0) begin
            $display("CHECK FAILED after reset: %s expected %h got %h", name, NS'(0), got);
            err_count++;
        end
    endtask

    task automatic check_frame(input int r);
        logic [7:0] exp_byte;
        logic       exp_user;
        int         n;
        if (hdr_count != 1) show_mismatch(r, "header count", 1, hdr_count);
        if (got_hdr[111:64] != rows[r].dest_mac) show_mismatch(r, "m_dest_mac",
            rows[r].dest_mac, got_hdr[111:64]);
        if (got_hdr[63:16] != rows[r].src_mac) show_mismatch(r, "m_src_mac",
            rows[r].src_mac, got_hdr[63:16]);
        if (got_hdr[15:0] != rows[r].eth_type) show_mismatch(r, "m_eth_type",
            rows[r].eth_type, got_hdr[15:0]);
        if (got_data.size() != rows[r].len) show_mismatch(r, "beat count", rows[r].len,
            got_data.size());
        n = (got_data.size() < rows[r].len) ? got_data.size() : rows[r].len;
        for (int k = 0; k < n; k++) begin
            exp_byte = rows[r].base + 8'(k);
            exp_user = (k == rows[r].len - 1) ? rows[r].tuser : 1'b0;
            if (got_data[k] != exp_byte) show_mismatch(r, "m_tdata", exp_byte, got_data[k]);
            if (got_last[k] != (k == rows[r].len - 1)) show_mismatch(r, "m_tlast",
                k == rows[r].len - 1, got_last[k]);
            if (got_user[k] != exp_user) show_mismatch(r, "m_tuser", exp_user, got_user[k]);
        end
        for (int i = 0; i < NS; i++) begin
            if (hdr_pulses[i] != (i == rows[r].src)) show_mismatch(r, "s_hdr_ready pulses",
                i == rows[r].src, hdr_pulses[i]);
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(51393));
        err_count   = 0;
        rst         = 1'b1;
        enable      = 1'b0;
        select      = '0;
        s_hdr_valid = '0;
        s_dest_mac  = '0;
        s_src_mac   = '0;
        s_eth_type  = '0;
        s_tdata     = '0;
        s_tuser     = '0;
        s_tlast     = '0;
        s_tvalid    = '0;
        m_hdr_ready = 1'b0;
        m_tready    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_reset_value("s_hdr_ready", s_hdr_ready);
        compare_reset_value("s_tready", s_tready);
        compare_reset_value("m_hdr_valid", m_hdr_valid);
        compare_reset_value("m_tvalid", m_tvalid);
        for (int r = 0; r < NUM_ROWS; r++) begin
            row_errs = 0;
            load_sources(r);
            enable = rows[r].en;
            if (!rows[r].en) begin
                repeat (30) step_cycle(r);
                for (int i = 0; i < NS; i++) begin
                    if (hdr_pulses[i] != 0) begin
                        $display("row %0d: a header was taken while enable was low", r);
                        row_errs++;
                    end
                end
                if (hdr_count != 0 || got_data.size() != 0) begin
                    $display("row %0d: output moved while enable was low", r);
                    row_errs++;
                end
                enable = 1'b1;
            end
            cycles = 0;
            while (!(src_done && tlast_seen && hdr_count != 0) && cycles < ROW_LIMIT) begin
                step_cycle(r);
                cycles++;
            end
            if (cycles >= ROW_LIMIT) begin
                $display("row %0d: frame from source %0d did not come out", r, rows[r].src);
                row_errs++;
            end else begin
                // a few idle cycles to catch extra beats or headers
                repeat (3) step_cycle(r);
                check_frame(r);
            end
            err_count += row_errs;
            $display("row %0d source %0d len %0d: %0d errors", r, rows[r].src,
                     rows[r].len, row_errs);
        end
        $display("%0d rows run, %0d checks failed", NUM_ROWS, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // backstop for a hung handshake
    initial begin
        #(NUM_ROWS * (MAX_LEN + 20) * 4 * CLK_PERIOD);
        $display("watchdog expired before all rows were done");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: eth_mux_top.f
+incdir+common
common/eth_mux_pkg.sv
common/eth_payload_if.sv
src/eth_mux_ctrl.sv
src/eth_hdr_out.sv
src/eth_payload_skid.sv
src/eth_mux_top.sv
tests/eth_mux_tb.sv

// File: Bender.yml
package:
  name: eth_mux

export_include_dirs:
  - common

sources:
  - files:
      - common/eth_mux_pkg.sv
      - common/eth_payload_if.sv
      - src/eth_mux_ctrl.sv
      - src/eth_hdr_out.sv
      - src/eth_payload_skid.sv
      - src/eth_mux_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/eth_mux_tb.sv
